// ==== icache_ctrl_unit.f ====
+incdir+include
source/icache_ctrl_pkg.sv
source/icache_reg_access_if.sv
source/icache_ctrl_fsm.sv
source/icache_ctrl_regs.sv
source/icache_maint_tracker.sv
source/icache_ctrl_unit.sv
tb/icache_ctrl_properties.sv
tb/icache_ctrl_unit_tb.sv

// ==== include/icache_ctrl_macros.svh ====
/* Sizes and register map of the instruction-cache control unit.
   Offsets are byte offsets on an 8-bit register address. */
`ifndef ICACHE_CTRL_MACROS_SVH
`define ICACHE_CTRL_MACROS_SVH

// Sizes
`define ICACHE_NB_CORES         4
`define ICACHE_NB_BANKS         2
`define ICACHE_ID_WIDTH         5

// Register map
`define ICACHE_REG_ENABLE       8'h00   // Enable or disable all caches
`define ICACHE_REG_FLUSH        8'h04   // Flush L1 and L2
`define ICACHE_REG_FLUSH_L1     8'h08   // Flush L1 only
`define ICACHE_REG_SEL_FLUSH    8'h0C   // Selective flush address
`define ICACHE_REG_SPECIAL_CFG  8'h18
`define ICACHE_REG_PREFETCH     8'h1C   // L1 to L1.5 prefetch mask

// Read value for offsets that map to nothing
`define ICACHE_UNMAPPED_DATA    32'hDEAD_CA5E

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module icache_ctrl_unit_tb \
    -Mdir "$BUILD_DIR" \
    -f icache_ctrl_unit.f

"$BUILD_DIR"/Vicache_ctrl_unit_tb | tee "$LOG_FILE"

if grep -q "Simulation finished: FAIL" "$LOG_FILE"; then
    echo "run_sim: testbench reported failure"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG_FILE"; then
    echo "run_sim: no result line in $LOG_FILE"
    exit 1
fi
echo "run_sim: testbench passed"

// ==== source/icache_ctrl_fsm.sv ====
/* Control FSM of the peripheral slave port. One access is in flight at most.
   A flush write with data bit zero has nothing to flush and answers at once. */
`default_nettype none

`include "icache_ctrl_macros.svh"

module icache_ctrl_fsm
    import icache_ctrl_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic                    req_i,
    input  logic                    wen_i,      // 1 means read
    input  reg_offset_t             addr_i,
    input  reg_word_t               wdata_i,
    input  req_id_t                 id_i,
    output logic                    gnt_o,
    output logic                    r_valid_o,
    output req_id_t                 r_id_o,

    icache_reg_access_if.fsm        regs_o,

    output logic                    start_o,
    output maint_op_e               op_o,
    input  logic                    done_i
);

    ctrl_state_e state_q, state_d;

    logic accept;
    logic is_read;
    logic is_write;
    logic maint_req;    // Write needs the cache handshake
    logic r_valid_d;
    logic is_flush_q;   // Running operation is a flush

    assign gnt_o    = (state_q == IDLE);
    assign accept   = req_i & gnt_o;
    assign is_read  = accept & wen_i;
    assign is_write = accept & ~wen_i;

    // Register bank strobes
    assign regs_o.rd_en       = is_read;
    assign regs_o.wr_en       = is_write;
    assign regs_o.offset      = addr_i;
    assign regs_o.wdata       = wdata_i;
    assign regs_o.clear_flush = (state_q == WAIT_MAINT) & done_i & is_flush_q;

    // Maintenance decode
    always_comb begin
        maint_req = 1'b0;
        op_o      = OP_ENABLE;
        case (addr_i)
            `ICACHE_REG_ENABLE: begin
                maint_req = 1'b1;
                op_o      = wdata_i[0] ? OP_ENABLE : OP_DISABLE;
            end
            `ICACHE_REG_FLUSH: begin
                maint_req = wdata_i[0];     // Zero data flushes nothing
                op_o      = OP_FLUSH;
            end
            `ICACHE_REG_FLUSH_L1: begin
                maint_req = wdata_i[0];
                op_o      = OP_FLUSH_L1;
            end
            `ICACHE_REG_SEL_FLUSH: begin
                maint_req = 1'b1;
                op_o      = OP_SEL_FLUSH;
            end
            default: begin
                maint_req = 1'b0;
            end
        endcase
    end

    assign start_o = is_write & maint_req;

    always_comb begin
        state_d   = state_q;
        r_valid_d = 1'b0;
        case (state_q)
            IDLE: begin
                if (start_o) begin
                    state_d = WAIT_MAINT;
                end else if (accept) begin
                    r_valid_d = 1'b1;   // Reads and plain writes
                end
            end
            WAIT_MAINT: begin
                if (done_i) begin
                    state_d   = IDLE;
                    r_valid_d = 1'b1;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            r_valid_o  <= 1'b0;
            is_flush_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            r_valid_o <= r_valid_d;
            if (start_o) begin
                is_flush_q <= (op_o == OP_FLUSH) || (op_o == OP_FLUSH_L1);
            end
        end
    end

    // Response ID follows the accepted request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            r_id_o <= id_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/icache_ctrl_pkg.sv ====
/* Types shared by the instruction-cache control unit.
   Mask widths follow the core and bank counts of the macros header. */
`default_nettype none

`include "icache_ctrl_macros.svh"

package icache_ctrl_pkg;

    typedef logic [31:0]                    reg_word_t;    // Data word or address
    typedef logic [7:0]                     reg_offset_t;
    typedef logic [`ICACHE_ID_WIDTH-1:0]    req_id_t;
    typedef logic [`ICACHE_NB_CORES-1:0]    core_mask_t;   // One bit per L1 cache
    typedef logic [`ICACHE_NB_BANKS-1:0]    bank_mask_t;   // One bit per L2 bank

    typedef enum logic [1:0] {
        IDLE,
        WAIT_MAINT      // Waiting on the cache acknowledges
    } ctrl_state_e;

    typedef enum logic [2:0] {
        OP_ENABLE,
        OP_DISABLE,
        OP_FLUSH,       // L1 and L2
        OP_FLUSH_L1,    // No L2 bank takes part
        OP_SEL_FLUSH
    } maint_op_e;

endpackage

`default_nettype wire

// ==== source/icache_ctrl_regs.sv ====
/* Control registers and read mux. Enable and flush registers hold one bit
   per core and per bank. Caches come out of reset disabled (bypassed). */
`default_nettype none

`include "icache_ctrl_macros.svh"

module icache_ctrl_regs
    import icache_ctrl_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,

    icache_reg_access_if.regs       regs_i,

    output core_mask_t              l1_bypass_req_o,
    output bank_mask_t              l2_enable_req_o,
    output bank_mask_t              l2_disable_req_o,
    output reg_word_t               sel_flush_addr_o,
    output logic                    special_cfg_o,
    output core_mask_t              prefetch_en_o
);

    core_mask_t enable_core_q;
    bank_mask_t enable_bank_q;
    core_mask_t flush_core_q;
    bank_mask_t flush_bank_q;
    reg_word_t  sel_addr_q;
    logic       special_q;
    core_mask_t prefetch_q;
    reg_word_t  rd_val;

    logic wbit;

    assign wbit = regs_i.wdata[0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_core_q <= '0;
            enable_bank_q <= '0;
            flush_core_q  <= '0;
            flush_bank_q  <= '0;
            sel_addr_q    <= '0;
            special_q     <= 1'b0;
            prefetch_q    <= '0;
        end else if (regs_i.wr_en) begin
            case (regs_i.offset)
                `ICACHE_REG_ENABLE: begin
                    enable_core_q <= {`ICACHE_NB_CORES{wbit}};
                    enable_bank_q <= {`ICACHE_NB_BANKS{wbit}};
                end
                `ICACHE_REG_FLUSH: begin
                    flush_core_q <= {`ICACHE_NB_CORES{wbit}};
                    flush_bank_q <= {`ICACHE_NB_BANKS{wbit}};
                end
                `ICACHE_REG_FLUSH_L1: begin
                    flush_core_q <= {`ICACHE_NB_CORES{wbit}};
                    flush_bank_q <= '0;     // L2 untouched
                end
                `ICACHE_REG_SEL_FLUSH:   sel_addr_q <= regs_i.wdata;
                `ICACHE_REG_SPECIAL_CFG: special_q  <= wbit;
                `ICACHE_REG_PREFETCH:    prefetch_q <= regs_i.wdata[`ICACHE_NB_CORES-1:0];
                default: begin
                    special_q <= special_q;     // Unmapped, no effect
                end
            endcase
        end else if (regs_i.clear_flush) begin
            flush_core_q <= '0;
            flush_bank_q <= '0;
        end
    end

    // Readback, banks above cores
    always_comb begin
        case (regs_i.offset)
            `ICACHE_REG_ENABLE:      rd_val = reg_word_t'({enable_bank_q, enable_core_q});
            `ICACHE_REG_FLUSH:       rd_val = reg_word_t'({flush_bank_q, flush_core_q});
            `ICACHE_REG_SEL_FLUSH:   rd_val = sel_addr_q;
            `ICACHE_REG_SPECIAL_CFG: rd_val = reg_word_t'(special_q);
            `ICACHE_REG_PREFETCH:    rd_val = reg_word_t'(prefetch_q);
            default:                 rd_val = `ICACHE_UNMAPPED_DATA;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (regs_i.rd_en) begin
            regs_i.rdata <= rd_val;
        end else if (regs_i.wr_en) begin
            regs_i.rdata <= '0;     // Write response carries no data
        end
    end

    // Cache side levels
    assign l1_bypass_req_o  = ~enable_core_q;
    assign l2_enable_req_o  =  enable_bank_q;
    assign l2_disable_req_o = ~enable_bank_q;
    assign sel_flush_addr_o = sel_addr_q;
    assign special_cfg_o    = special_q;
    assign prefetch_en_o    = prefetch_q;

endmodule

`default_nettype wire

// ==== source/icache_ctrl_unit.sv ====
/* Top level of the instruction-cache control unit.
   Read data comes straight from the register bank. */
`default_nettype none

module icache_ctrl_unit
    import icache_ctrl_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // Peripheral slave port
    input  logic                    req_i,
    input  logic                    wen_i,
    input  reg_offset_t             addr_i,
    input  reg_word_t               wdata_i,
    input  req_id_t                 id_i,
    output logic                    gnt_o,
    output logic                    r_valid_o,
    output req_id_t                 r_id_o,
    output reg_word_t               r_rdata_o,

    // Cache side
    output core_mask_t              l1_bypass_req_o,
    input  core_mask_t              l1_bypass_ack_i,
    output bank_mask_t              l2_enable_req_o,
    input  bank_mask_t              l2_enable_ack_i,
    output bank_mask_t              l2_disable_req_o,
    input  bank_mask_t              l2_disable_ack_i,
    output core_mask_t              l1_flush_req_o,
    input  core_mask_t              l1_flush_ack_i,
    output bank_mask_t              l2_flush_req_o,
    input  bank_mask_t              l2_flush_ack_i,
    output core_mask_t              l1_sel_flush_req_o,
    input  core_mask_t              l1_sel_flush_ack_i,
    output bank_mask_t              l2_sel_flush_req_o,
    input  bank_mask_t              l2_sel_flush_ack_i,
    output reg_word_t               sel_flush_addr_o,
    output logic                    special_cfg_o,
    output core_mask_t              prefetch_en_o
);

    icache_reg_access_if regs_if ();

    logic      maint_start;
    maint_op_e maint_op;
    logic      maint_done;

    assign r_rdata_o = regs_if.rdata;

    icache_ctrl_fsm fsm_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (req_i),
        .wen_i     (wen_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .id_i      (id_i),
        .gnt_o     (gnt_o),
        .r_valid_o (r_valid_o),
        .r_id_o    (r_id_o),
        .regs_o    (regs_if.fsm),
        .start_o   (maint_start),
        .op_o      (maint_op),
        .done_i    (maint_done)
    );

    icache_ctrl_regs regs_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .regs_i           (regs_if.regs),
        .l1_bypass_req_o  (l1_bypass_req_o),
        .l2_enable_req_o  (l2_enable_req_o),
        .l2_disable_req_o (l2_disable_req_o),
        .sel_flush_addr_o (sel_flush_addr_o),
        .special_cfg_o    (special_cfg_o),
        .prefetch_en_o    (prefetch_en_o)
    );

    icache_maint_tracker tracker_i (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .start_i            (maint_start),
        .op_i               (maint_op),
        .l1_bypass_ack_i    (l1_bypass_ack_i),
        .l2_enable_ack_i    (l2_enable_ack_i),
        .l2_disable_ack_i   (l2_disable_ack_i),
        .l1_flush_ack_i     (l1_flush_ack_i),
        .l2_flush_ack_i     (l2_flush_ack_i),
        .l1_sel_flush_ack_i (l1_sel_flush_ack_i),
        .l2_sel_flush_ack_i (l2_sel_flush_ack_i),
        .l1_flush_req_o     (l1_flush_req_o),
        .l1_sel_flush_req_o (l1_sel_flush_req_o),
        .l2_flush_req_o     (l2_flush_req_o),
        .l2_sel_flush_req_o (l2_sel_flush_req_o),
        .done_o             (maint_done)
    );

endmodule

`default_nettype wire

// ==== source/icache_maint_tracker.sv ====
/* Tracks outstanding acknowledges of one maintenance operation.
   start_i must only come while no operation is running. */
`default_nettype none

module icache_maint_tracker
    import icache_ctrl_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic                    start_i,
    input  maint_op_e               op_i,

    input  core_mask_t              l1_bypass_ack_i,
    input  bank_mask_t              l2_enable_ack_i,
    input  bank_mask_t              l2_disable_ack_i,
    input  core_mask_t              l1_flush_ack_i,
    input  bank_mask_t              l2_flush_ack_i,
    input  core_mask_t              l1_sel_flush_ack_i,
    input  bank_mask_t              l2_sel_flush_ack_i,

    output core_mask_t              l1_flush_req_o,
    output core_mask_t              l1_sel_flush_req_o,
    output bank_mask_t              l2_flush_req_o,
    output bank_mask_t              l2_sel_flush_req_o,
    output logic                    done_o
);

    maint_op_e  op_q;
    logic       busy_q;
    core_mask_t core_pend_q;
    bank_mask_t bank_pend_q;

    core_mask_t core_hit;       // Cores answering as expected this cycle
    bank_mask_t bank_hit;
    core_mask_t core_left;
    bank_mask_t bank_left;
    logic       is_flush;
    logic       is_sel;

    always_comb begin
        core_hit = '0;
        bank_hit = '0;
        case (op_q)
            OP_ENABLE: begin
                core_hit = ~l1_bypass_ack_i;    // Bypass released
                bank_hit =  l2_enable_ack_i;
            end
            OP_DISABLE: begin
                core_hit = l1_bypass_ack_i;
                bank_hit = l2_disable_ack_i;
            end
            OP_FLUSH, OP_FLUSH_L1: begin
                core_hit = l1_flush_ack_i;
                bank_hit = l2_flush_ack_i;
            end
            OP_SEL_FLUSH: begin
                core_hit = l1_sel_flush_ack_i;
                bank_hit = l2_sel_flush_ack_i;
            end
            default: begin
                core_hit = '0;
            end
        endcase
    end

    assign core_left = core_pend_q & ~core_hit;
    assign bank_left = bank_pend_q & ~bank_hit;
    assign done_o    = busy_q && (core_left == '0) && (bank_left == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            op_q        <= OP_ENABLE;
            busy_q      <= 1'b0;
            core_pend_q <= '0;
            bank_pend_q <= '0;
        end else if (start_i) begin
            op_q        <= op_i;
            busy_q      <= 1'b1;
            core_pend_q <= '1;
            bank_pend_q <= (op_i == OP_FLUSH_L1) ? '0 : '1;  // L1-only spares the banks
        end else begin
            core_pend_q <= core_left;
            bank_pend_q <= bank_left;
            if (done_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Requests stay up until their own acknowledge
    assign is_flush = (op_q == OP_FLUSH) || (op_q == OP_FLUSH_L1);
    assign is_sel   = (op_q == OP_SEL_FLUSH);

    assign l1_flush_req_o     = is_flush ? core_pend_q : '0;
    assign l2_flush_req_o     = is_flush ? bank_pend_q : '0;
    assign l1_sel_flush_req_o = is_sel   ? core_pend_q : '0;
    assign l2_sel_flush_req_o = is_sel   ? bank_pend_q : '0;

endmodule

`default_nettype wire

// ==== source/icache_reg_access_if.sv ====
/* Register access path from the control FSM to the register bank.
   wr_en, rd_en and clear_flush are one-cycle strobes. */
`default_nettype none

interface icache_reg_access_if
    import icache_ctrl_pkg::*;
();

    logic        wr_en;         // Write in the accept cycle
    logic        rd_en;         // Read in the accept cycle
    reg_offset_t offset;
    reg_word_t   wdata;
    reg_word_t   rdata;         // Registered read data
    logic        clear_flush;   // End of a flush

    // Control side
    modport fsm (
        output wr_en,
        output rd_en,
        output offset,
        output wdata,
        output clear_flush
    );

    // Storage side
    modport regs (
        input  wr_en,
        input  rd_en,
        input  offset,
        input  wdata,
        input  clear_flush,
        output rdata
    );

endinterface

`default_nettype wire

// ==== tb/icache_ctrl_cases.txt ====
// Columns: kind (1 read, 0 write, f end), offset, wdata, id, expected rdata
// Write responses carry zero rdata; values assume 4 cores and 2 banks
1 00 00000000 01 00000000
1 04 00000000 02 00000000
1 0C 00000000 03 00000000
1 18 00000000 04 00000000
1 1C 00000000 05 00000000
1 10 00000000 06 DEADCA5E
0 00 00000001 07 00000000
1 00 00000000 08 0000003F
0 04 00000001 09 00000000
1 04 00000000 0A 00000000
0 08 00000001 0B 00000000
1 04 00000000 0C 00000000
0 04 00000000 0D 00000000
0 0C 12345678 0E 00000000
1 0C 00000000 0F 12345678
0 18 00000001 10 00000000
1 18 00000000 11 00000001
0 1C 00000005 12 00000000
1 1C 00000000 13 00000005
0 14 0000ABCD 14 00000000
1 14 00000000 15 DEADCA5E
0 00 00000000 16 00000000
1 00 00000000 17 00000000
f 00 00000000 00 00000000

// ==== tb/icache_ctrl_properties.sv ====
/* Protocol assertions on the control unit, bound to every instance of the top level.
   Assumes each cache holds its acknowledge once it matches the request level. */
`default_nettype none

module icache_ctrl_properties
    import icache_ctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       gnt_i,
    input  logic       r_valid_i,
    input  bank_mask_t l2_enable_req_i,
    input  core_mask_t l1_bypass_ack_i,
    input  bank_mask_t l2_enable_ack_i,
    input  bank_mask_t l2_disable_ack_i,
    input  core_mask_t l1_flush_req_i,
    input  bank_mask_t l2_flush_req_i,
    input  core_mask_t l1_sel_flush_req_i,
    input  bank_mask_t l2_sel_flush_req_i
);

    logic caches_settled;   // Enable state acknowledged by every cache
    logic flush_any;

    assign caches_settled = (l2_enable_req_i == '1) ?
                            (l1_bypass_ack_i == '0 && l2_enable_ack_i == '1) :
                            (l1_bypass_ack_i == '1 && l2_disable_ack_i == '1);

    assign flush_any = (l1_flush_req_i != '0) || (l2_flush_req_i != '0) ||
                       (l1_sel_flush_req_i != '0) || (l2_sel_flush_req_i != '0);

    no_grant_while_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
        gnt_i |-> caches_settled) else $error("grant high before all caches acknowledged");

    single_cycle_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_i |=> !r_valid_i) else $error("r_valid_o held for more than one cycle");

    no_flush_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        gnt_i |-> !flush_any) else $error("flush request high while idle");

endmodule

bind icache_ctrl_unit icache_ctrl_properties props_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .gnt_i              (gnt_o),
    .r_valid_i          (r_valid_o),
    .l2_enable_req_i    (l2_enable_req_o),
    .l1_bypass_ack_i    (l1_bypass_ack_i),
    .l2_enable_ack_i    (l2_enable_ack_i),
    .l2_disable_ack_i   (l2_disable_ack_i),
    .l1_flush_req_i     (l1_flush_req_o),
    .l2_flush_req_i     (l2_flush_req_o),
    .l1_sel_flush_req_i (l1_sel_flush_req_o),
    .l2_sel_flush_req_i (l2_sel_flush_req_o)
);

`default_nettype wire

// ==== tb/icache_ctrl_unit_tb.sv ====
/* Testbench of the instruction-cache control unit, built for 4 cores and 2 banks.
   Accesses and expected read data come from tb/icache_ctrl_cases.txt. */
`default_nettype none

`include "icache_ctrl_macros.svh"

module icache_ctrl_unit_tb
    import icache_ctrl_pkg::*;
();

    localparam int    CLK_PERIOD = 8;
    localparam int    RST_CYCLES = 16;
    localparam int    TIMEOUT    = 200;     // Cycles per wait
    localparam int    MAX_CASES  = 64;
    localparam string CASE_FILE  = "tb/icache_ctrl_cases.txt";
    localparam logic [31:0] SEED_INIT = 32'hc079_224e;
    localparam logic [31:0] END_MARK  = 32'hF;
    localparam int    NC         = `ICACHE_NB_CORES;
    localparam int    NB         = `ICACHE_NB_BANKS;
    localparam int    ACK_BITS   = 3 * NC + 4 * NB;

    // Ack order {l2 sel, l2 flush, l2 disable, l2 enable, l1 sel, l1 flush, l1 bypass}
    localparam logic [ACK_BITS-1:0] FALL_NOW  =
        {{(2 * NB){1'b1}}, {(2 * NB){1'b0}}, {(2 * NC){1'b1}}, {NC{1'b0}}};
    localparam logic [ACK_BITS-1:0] ACK_RESET =
        {{(2 * NB){1'b0}}, {NB{1'b1}}, {NB{1'b0}}, {(2 * NC){1'b0}}, {NC{1'b1}}};

    logic        clk_i;
    logic        rst_ni;
    logic        req_i;
    logic        wen_i;
    reg_offset_t addr_i;
    reg_word_t   wdata_i;
    req_id_t     id_i;
    logic        gnt_o;
    logic        r_valid_o;
    req_id_t     r_id_o;
    reg_word_t   r_rdata_o;
    core_mask_t  l1_bypass_req_o, l1_bypass_ack_i;
    bank_mask_t  l2_enable_req_o, l2_enable_ack_i;
    bank_mask_t  l2_disable_req_o, l2_disable_ack_i;
    core_mask_t  l1_flush_req_o, l1_flush_ack_i;
    bank_mask_t  l2_flush_req_o, l2_flush_ack_i;
    core_mask_t  l1_sel_flush_req_o, l1_sel_flush_ack_i;
    bank_mask_t  l2_sel_flush_req_o, l2_sel_flush_ack_i;
    reg_word_t   sel_flush_addr_o;
    logic        special_cfg_o;
    core_mask_t  prefetch_en_o;

    logic [ACK_BITS-1:0] req_all;
    logic [ACK_BITS-1:0] ack_all = ACK_RESET;
    int unsigned         delay_q [ACK_BITS];
    integer              seed = SEED_INIT;
    logic [31:0]         case_mem [5*MAX_CASES];
    int                  errors = 0;
    int                  tests_ok = 0;
    int                  tests_bad = 0;
    logic                timed_out = 1'b0;
    logic                case_bad = 1'b0;

    icache_ctrl_unit dut_i (.*);

    assign req_all = {l2_sel_flush_req_o, l2_flush_req_o, l2_disable_req_o, l2_enable_req_o,
                      l1_sel_flush_req_o, l1_flush_req_o, l1_bypass_req_o};
    assign {l2_sel_flush_ack_i, l2_flush_ack_i, l2_disable_ack_i, l2_enable_ack_i,
            l1_sel_flush_ack_i, l1_flush_ack_i, l1_bypass_ack_i} = ack_all;

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Cache models, each ack follows its request after a random delay
    always @(negedge clk_i) begin
        if (rst_ni) begin
            for (int i = 0; i < ACK_BITS; i++) begin
                if (ack_all[i] == req_all[i]) begin
                    delay_q[i] = $unsigned($random(seed)) % 6;
                end else if (FALL_NOW[i] && !req_all[i]) begin
                    ack_all[i] = 1'b0;      // Flush ack ends with its request
                end else if (delay_q[i] == 0) begin
                    ack_all[i] = req_all[i];
                end else begin
                    delay_q[i] = delay_q[i] - 1;
                end
            end
        end
    end

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            $display("[ERROR] %0t: %s", $time, what);
            errors++;
            case_bad = 1'b1;
        end
    endtask

    task automatic close_case(input string label);
        $display("%s: %s", label, case_bad ? "mismatch" : "ok");
        if (case_bad) begin
            tests_bad++;
        end else begin
            tests_ok++;
        end
        case_bad = 1'b0;
    endtask

    task automatic run_access(input int idx);
        logic        is_rd;
        reg_offset_t off;
        reg_word_t   data;
        req_id_t     id;
        reg_word_t   exp_rd;
        int          cycles;
        logic        l2_seen;
        logic        maint;
        is_rd  = case_mem[5*idx][0];
        off    = case_mem[5*idx+1][7:0];
        data   = case_mem[5*idx+2];
        id     = case_mem[5*idx+3][`ICACHE_ID_WIDTH-1:0];
        exp_rd = case_mem[5*idx+4];
        maint  = !is_rd && (off == `ICACHE_REG_ENABLE || off == `ICACHE_REG_SEL_FLUSH ||
                 (data[0] && (off == `ICACHE_REG_FLUSH || off == `ICACHE_REG_FLUSH_L1)));
        req_i   = 1'b1;
        wen_i   = is_rd;
        addr_i  = off;
        wdata_i = data;
        id_i    = id;
        cycles  = 0;
        while (!gnt_o) begin
            if (cycles == TIMEOUT) begin
                $display("Timeout: case %0d was not granted within %0d cycles", idx, TIMEOUT);
                timed_out = 1'b1;
                return;
            end
            @(negedge clk_i);
            cycles++;
        end
        @(negedge clk_i);   // Accepted at the last rising edge
        req_i = 1'b0;
        if (maint && (off == `ICACHE_REG_FLUSH || off == `ICACHE_REG_FLUSH_L1)) begin
            check(l1_flush_req_o == '1, "L1 flush requests not raised");
            check(l2_flush_req_o == (off == `ICACHE_REG_FLUSH ? '1 : '0), "L2 flush requests wrong");
        end
        if (maint && off == `ICACHE_REG_SEL_FLUSH) begin
            check(l1_sel_flush_req_o == '1 && l2_sel_flush_req_o == '1,
                  "selective flush requests not raised");
        end
        cycles  = 0;
        l2_seen = (l2_flush_req_o != '0);
        while (!r_valid_o) begin
            if (cycles == TIMEOUT) begin
                $display("Timeout: no response to case %0d within %0d cycles", idx, TIMEOUT);
                timed_out = 1'b1;
                return;
            end
            @(negedge clk_i);
            cycles++;
            l2_seen = l2_seen | (l2_flush_req_o != '0);
        end
        check(r_id_o == id, $sformatf("r_id_o 0x%0h, expected 0x%0h", r_id_o, id));
        check(r_rdata_o == exp_rd, $sformatf("r_rdata_o 0x%08h, expected 0x%08h", r_rdata_o, exp_rd));
        check(maint ? (cycles >= 1) : (cycles == 0),
              $sformatf("response %0d cycles after accept", cycles + 1));
        if (!is_rd) begin
            case (off)
                `ICACHE_REG_ENABLE: begin
                    check(l1_bypass_req_o == {NC{~data[0]}}, "l1_bypass_req_o wrong");
                    check(l2_enable_req_o == {NB{data[0]}}, "l2_enable_req_o wrong");
                    check(l2_disable_req_o == {NB{~data[0]}}, "l2_disable_req_o wrong");
                    check(data[0] ? (l1_bypass_ack_i == '0 && l2_enable_ack_i == '1)
                                  : (l1_bypass_ack_i == '1 && l2_disable_ack_i == '1),
                          "answered before all acknowledges");
                end
                `ICACHE_REG_FLUSH, `ICACHE_REG_FLUSH_L1: begin
                    check(l1_flush_req_o == '0 && l2_flush_req_o == '0, "flush request still high");
                    check(!(off == `ICACHE_REG_FLUSH_L1 && l2_seen), "L2 flushed by L1-only flush");
                end
                `ICACHE_REG_SEL_FLUSH: begin
                    check(sel_flush_addr_o == data, "sel_flush_addr_o wrong");
                    check(l1_sel_flush_req_o == '0 && l2_sel_flush_req_o == '0,
                          "selective flush request still high");
                end
                `ICACHE_REG_SPECIAL_CFG: check(special_cfg_o == data[0], "special_cfg_o wrong");
                `ICACHE_REG_PREFETCH:    check(prefetch_en_o == data[NC-1:0], "prefetch_en_o wrong");
                default: ;
            endcase
        end
        close_case($sformatf("case %0d %s 0x%02h", idx, is_rd ? "read" : "write", off));
        @(negedge clk_i);   // Idle cycle between accesses
    endtask

    initial begin
        int idx;
        rst_ni  = 1'b0;
        req_i   = 1'b0;
        wen_i   = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        id_i    = '0;
        for (int i = 0; i < 5 * MAX_CASES; i++) begin
            case_mem[i] = END_MARK;
        end
        $readmemh(CASE_FILE, case_mem);
        repeat (RST_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        check(gnt_o && !r_valid_o, "grant or response wrong after reset");
        check(l1_flush_req_o == '0 && l2_flush_req_o == '0, "flush request high after reset");
        check(l1_sel_flush_req_o == '0 && l2_sel_flush_req_o == '0, "selective flush after reset");
        check(!special_cfg_o && prefetch_en_o == '0, "configuration set after reset");
        check(l1_bypass_req_o == '1 && l2_disable_req_o == '1 && l2_enable_req_o == '0,
              "caches not disabled after reset");
        close_case("reset values");
        idx = 0;
        while (idx < MAX_CASES && case_mem[5*idx] != END_MARK && !timed_out) begin
            run_access(idx);
            idx++;
        end
        if (idx == 0) begin
            $display("No cases were read from %s", CASE_FILE);
        end
        $display("Tests: %0d ok, %0d with mismatches, %0d errors", tests_ok, tests_bad, errors);
        if (timed_out || errors != 0 || idx == 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire
